// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int APB_ADDR_W = 8;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;

    // apb address map
    localparam logic [APB_ADDR_W-1:0] ISSUE_ADDR = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_BASE   = 8'h80;   // x0..x31 at 0x80..0xfc

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     use_imm;
        word_t    imm;      // already sign extended
        logic     reg_write;
    } dec_op_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     reg_write;
        word_t    a;
        word_t    b;
    } exe_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

endpackage

// File: hdl/apb_issue_port.sv
`timescale 1ns/100ps

module apb_issue_port (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [rv_core_pkg::APB_ADDR_W-1:0] paddr,
    input  rv_core_pkg::word_t                pwdata,
    output rv_core_pkg::word_t                prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              pipe_busy,
    output rv_core_pkg::reg_idx_t             rd_idx,
    input  rv_core_pkg::word_t                rd_data,
    output logic                              issue_valid,
    output rv_core_pkg::word_t                issue_instr
);
    import rv_core_pkg::*;

    logic [APB_ADDR_W-1:0] reg_offset;
    logic                  is_issue_wr;
    logic                  is_reg_rd;
    logic                  is_bad;
    logic                  access;
    logic                  busy;

    assign reg_offset  = paddr - REG_BASE;
    assign is_issue_wr = pwrite && (paddr == ISSUE_ADDR);
    assign is_reg_rd   = !pwrite && (paddr >= REG_BASE) && (paddr[1:0] == 2'b00);
    assign is_bad      = !is_issue_wr && !is_reg_rd;
    assign access      = psel && penable;

    // an issued word is still in the apb port for one cycle
    assign busy = pipe_busy | issue_valid;

    assign rd_idx  = reg_offset[6:2];
    assign pready  = access && (is_issue_wr || is_bad || (is_reg_rd && !busy));
    assign pslverr = access && is_bad;
    assign prdata  = (access && is_reg_rd) ? rd_data : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pready && is_issue_wr;   // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (pready && is_issue_wr) begin
            issue_instr <= pwdata;
        end
    end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  rv_core_pkg::word_t   issue_instr,
    output rv_core_pkg::dec_op_t dec
);
    import rv_core_pkg::*;

    instr_u  ins;
    dec_op_t dec_d;
    logic    known;

    // alt selects SUB over ADD and SRA over SRL
    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign ins = issue_instr;

    always_comb begin
        dec_d         = '0;
        known         = 1'b1;
        dec_d.valid   = issue_valid;
        dec_d.rs1     = ins.r.rs1;
        dec_d.rs2     = ins.r.rs2;
        dec_d.rd      = ins.r.rd;
        dec_d.imm     = {{(XLEN-12){ins.i.imm12[11]}}, ins.i.imm12};
        dec_d.alu_op  = ALU_ADD;
        case (ins.r.opcode)
            OPC_OP: begin
                dec_d.alu_op = alu_sel(ins.r.funct3, ins.r.funct7[5]);
            end
            OPC_OP_IMM: begin
                dec_d.use_imm = 1'b1;
                // no SUBI, so bit 30 only matters for shifts
                dec_d.alu_op  = alu_sel(ins.i.funct3,
                                        (ins.i.funct3 == F3_SR) && ins.i.imm12[10]);
            end
            default: known = 1'b0;   // no-op
        endcase
        dec_d.reg_write = known && (ins.r.rd != '0);
    end

    always_ff @(posedge clk) begin
        dec <= dec_d;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/operand_stage.sv
`timescale 1ns/100ps

module operand_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::dec_op_t  dec,
    input  rv_core_pkg::wb_t      wb,
    input  rv_core_pkg::reg_idx_t rd_idx,
    output rv_core_pkg::word_t    rd_data,
    output rv_core_pkg::exe_op_t  exe,
    output logic                  pipe_busy
);
    import rv_core_pkg::*;

    word_t   regs [REG_COUNT];
    exe_op_t exe_d;

    // register read with bypass from the write-back record
    function automatic word_t read_fwd(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.valid && (wb.rd == idx)) begin
            return wb.value;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.value;
        end
    end

    always_comb begin
        rd_data = read_fwd(rd_idx);
    end

    always_comb begin
        exe_d.valid     = dec.valid;
        exe_d.alu_op    = dec.alu_op;
        exe_d.rd        = dec.rd;
        exe_d.reg_write = dec.reg_write;
        exe_d.a         = read_fwd(dec.rs1);
        exe_d.b         = dec.use_imm ? dec.imm : read_fwd(dec.rs2);
    end

    always_ff @(posedge clk) begin
        exe <= exe_d;
        if (!rst_n) begin
            exe.valid <= 1'b0;
        end
    end

    assign pipe_busy = dec.valid | exe.valid | wb.valid;

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_core_pkg::exe_op_t exe,
    output rv_core_pkg::wb_t     wb
);
    import rv_core_pkg::*;

    word_t      result;
    logic [4:0] shamt;

    assign shamt = exe.b[4:0];   // rv32 shift amount

    always_comb begin
        case (exe.alu_op)
            ALU_ADD:  result = exe.a + exe.b;
            ALU_SUB:  result = exe.a - exe.b;
            ALU_AND:  result = exe.a & exe.b;
            ALU_OR:   result = exe.a | exe.b;
            ALU_XOR:  result = exe.a ^ exe.b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(exe.a) < $signed(exe.b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, exe.a < exe.b};
            ALU_SLL:  result = exe.a << shamt;
            ALU_SRL:  result = exe.a >> shamt;
            ALU_SRA:  result = $signed(exe.a) >>> shamt;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        wb.rd    <= exe.rd;
        wb.value <= result;
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= exe.valid && exe.reg_write;   // no-ops retire silently
        end
    end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [rv_core_pkg::APB_ADDR_W-1:0] paddr,
    input  rv_core_pkg::word_t                pwdata,
    output rv_core_pkg::word_t                prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import rv_core_pkg::*;

    logic     issue_valid;
    word_t    issue_instr;
    logic     pipe_busy;
    reg_idx_t rd_idx;
    word_t    rd_data;

    dec_op_t  dec;
    exe_op_t  exe;
    wb_t      wb;

    apb_issue_port u_apb_issue_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .pipe_busy   (pipe_busy),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .dec         (dec)
    );

    operand_stage u_operand_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .wb        (wb),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .exe       (exe),
        .pipe_busy (pipe_busy)
    );

    execute_stage u_execute_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .exe   (exe),
        .wb    (wb)
    );

endmodule

// File: testbench/rv_core_assert.sv
`timescale 1ns/100ps

module rv_core_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        psel, penable, pwrite,
    input logic [7:0]  paddr,
    input logic [31:0] pwdata,
    input logic        pready,
    input logic        issue_valid
);

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !pready)
        else $error("pready high while in reset");

    // master holds everything until pready
    master_hold: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && !pready |=> psel && penable && $stable(pwrite)
            && $stable(paddr) && $stable(pwdata))
        else $error("apb master changed signals during a wait state");

    issue_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |=> !issue_valid)
        else $error("issue_valid held longer than one cycle");

endmodule

bind rv_core_top rv_core_assert u_rv_core_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .issue_valid (issue_valid)
);

// File: testbench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel, penable, pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata, prdata,
    input  logic        pready, pslverr,
    input  logic        exp_err,
    output int          checks,
    output int          errors
);
    // falling edges from an issue until a read may complete
    localparam int WR_DRAIN  = 5;   // write lands on the fourth rising edge
    localparam int NOP_DRAIN = 4;   // no write-back cycle

    logic [31:0] model [32];
    int          since_issue;
    int          ready_at;
    logic        exp_rdy;
    logic        wr;

    // reference rv32i semantics for the two integer opcodes
    task automatic retire(input logic [31:0] w, output logic writes);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] sra;
        logic        alt;
        logic        imm_form;
        imm_form = (w[6:0] == 7'b0010011);
        a        = model[w[19:15]];
        b        = imm_form ? {{20{w[31]}}, w[31:20]} : model[w[24:20]];
        alt      = w[30] && (!imm_form || w[14:12] == 3'd5);   // sub, sra, srai
        sra      = $signed(a) >>> b[4:0];
        case (w[14:12])
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = {31'd0, $signed(a) < $signed(b)};
            3'd3:    r = {31'd0, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? sra : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        writes = (imm_form || w[6:0] == 7'b0110011) && w[11:7] != 5'd0;
        if (writes) begin
            model[w[11:7]] = r;
        end
    endtask

    // outputs are settled half a cycle after the drive edge
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
            since_issue = 0;
            ready_at    = 0;
        end else begin
            since_issue++;
            if (psel && penable) begin
                exp_rdy = exp_err || pwrite || (since_issue >= ready_at);
                if (pready !== exp_rdy) begin
                    errors++;
                    $display("FAIL t=%0t pready: expected %0b, got %0b",
                             $time, exp_rdy, pready);
                end
            end
            if (psel && penable && pready) begin
                checks++;
                if (pslverr !== exp_err) begin
                    errors++;
                    $display("FAIL t=%0t pslverr: expected %0b, got %0b",
                             $time, exp_err, pslverr);
                end
                if (!exp_err && pwrite) begin
                    retire(pwdata, wr);
                    ready_at    = wr ? WR_DRAIN : NOP_DRAIN;
                    since_issue = 0;
                end else if (!exp_err && prdata !== model[paddr[6:2]]) begin
                    errors++;
                    $display("FAIL t=%0t prdata x%0d: expected %08h, got %08h",
                             $time, paddr[6:2], model[paddr[6:2]], prdata);
                end
            end
        end
    end

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

    localparam logic [1:0] K_ISSUE  = 2'd0;
    localparam logic [1:0] K_READ   = 2'd1;
    localparam logic [1:0] K_BAD_RD = 2'd2;
    localparam logic [1:0] K_BAD_WR = 2'd3;

    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  addr;
        logic [31:0] data;
        logic        exp_err;
    } entry_t;

    logic        clk, rst_n;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr, exp_err;
    int          checks, errors;
    int          cycles;
    int          limit;
    entry_t      stim_q [$];

    rv_core_top i_rv_core_top (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    tb_checker u_checker (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .exp_err(exp_err), .checks(checks), .errors(errors)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] op_rr(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic add_entry(input logic [1:0] kind, input logic [7:0] addr,
                             input logic [31:0] data, input logic err);
        stim_q.push_back('{kind: kind, addr: addr, data: data, exp_err: err});
    endtask

    task automatic add_issue(input logic [31:0] w);
        add_entry(K_ISSUE, 8'h00, w, 1'b0);
    endtask

    task automatic add_read(input int n);
        add_entry(K_READ, {1'b1, 5'(n), 2'b00}, 32'd0, 1'b0);
    endtask

    task automatic build_stimulus();
        logic [11:0] imm;
        for (int n = 0; n < 32; n++) add_read(n);   // reset state
        // dependent chains build wide operands in x1 and x2
        for (int n = 1; n <= 2; n++) begin
            add_issue(op_imm(12'($urandom()), 5'd0, 3'd0, 5'(n)));
            add_issue(op_imm(12'd20, 5'(n), 3'd1, 5'(n)));
            add_issue(op_imm(12'($urandom()), 5'(n), 3'd4, 5'(n)));
            add_read(n);
        end
        for (int k = 0; k < 8; k++) begin
            add_issue(op_rr(7'h00, 5'd2, 5'd1, 3'(k), 5'(10 + k)));
            add_read(10 + k);
        end
        add_issue(op_rr(7'h20, 5'd2, 5'd1, 3'd0, 5'd18));   // sub
        add_read(18);
        add_issue(op_rr(7'h20, 5'd2, 5'd1, 3'd5, 5'd19));   // sra
        add_read(19);
        for (int k = 0; k < 9; k++) begin
            imm = 12'($urandom());
            if (k == 1 || k >= 5 && k != 6 && k != 7) imm = {7'h00, imm[4:0]};
            if (k == 8) imm = {7'h20, imm[4:0]};              // srai
            add_issue(op_imm(imm, 5'd1, 3'(k == 8 ? 5 : k), 5'(20 + k)));
            add_read(20 + k);
        end
        add_issue(op_imm(12'h055, 5'd1, 3'd0, 5'd0));
        add_issue(op_rr(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        add_issue({12'h123, 5'd1, 3'd2, 5'd5, 7'b0000011});   // load, no-op here
        add_issue({20'h12345, 5'd6, 7'b0110111});             // lui, no-op here
        add_read(0);
        add_entry(K_BAD_RD, 8'h00, 32'd0, 1'b1);
        add_entry(K_BAD_WR, 8'h84, op_imm(12'h5a5, 5'd0, 3'd0, 5'd3), 1'b1);
        add_entry(K_BAD_RD, 8'h82, 32'd0, 1'b1);
        add_entry(K_BAD_WR, 8'h40, op_imm(12'h0c3, 5'd0, 3'd6, 5'd4), 1'b1);
        for (int n = 0; n < 32; n++) add_read(n);
    endtask

    task automatic apb_xfer(input entry_t e);
        logic done;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = (e.kind == K_ISSUE) || (e.kind == K_BAD_WR);
        paddr   = e.addr;
        pwdata  = e.data;
        exp_err = e.exp_err;
        @(posedge clk);
        #2 penable = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = pready;
            @(posedge clk);
        end
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        exp_err = 1'b0;
        void'($urandom(32'h352a92b5));
        build_stimulus();
        limit = 40 * stim_q.size() + 100;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        foreach (stim_q[i]) apb_xfer(stim_q[i]);
        repeat (2) @(posedge clk);
        if (checks != stim_q.size()) $display("only %0d of %0d transfers were checked",
                                              checks, stim_q.size());
        $display("transfers checked: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks == stim_q.size()) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
hdl/rv_core_pkg.sv
hdl/apb_issue_port.sv
hdl/decode_stage.sv
hdl/operand_stage.sv
hdl/execute_stage.sv
hdl/rv_core_top.sv
testbench/rv_core_assert.sv
testbench/tb_checker.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f sim.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

# an assertion abort leaves neither message in the log
if grep -qF '*** FAILED ***' sim.log || ! grep -qF '*** PASSED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation ok"
